//--- Bender.yml
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - inst_decoder.sv
  - regfile.sv
  - operand_forward.sv
  - branch_unit.sv
  - decode_stage.sv
  - target: simulation
    files:
      - tb_decode_stage.sv

//--- branch_unit.sv
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  br_op_e          br_op,
    input  logic [XLEN-1:0] offset,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    output redirect_t       result
);

    logic [XLEN:0]   diff;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic [XLEN-1:0] base;

    // rj - rkd as rj + ~rkd + 1, carry out in the top bit
    assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + (XLEN+1)'(1);
    assign eq   = (diff[XLEN-1:0] == '0);
    // carry set means no borrow, rj >= rkd unsigned
    assign lt_u = !diff[XLEN];
    // signs differ: the negative one is smaller
    // signs equal: sign of the difference decides
    assign lt_s = (rj_value[XLEN-1] != rkd_value[XLEN-1]) ? rj_value[XLEN-1]
                                                           : diff[XLEN-1];

    always_comb begin
        case (br_op)
            BR_B, BR_BL, BR_JIRL: taken = 1'b1;
            BR_BEQ:               taken = eq;
            BR_BNE:               taken = !eq;
            BR_BLT:               taken = lt_s;
            BR_BGE:               taken = !lt_s;
            BR_BLTU:              taken = lt_u;
            BR_BGEU:              taken = !lt_u;
            default:              taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign base          = (br_op == BR_JIRL) ? rj_value : pc;
    assign result.taken  = taken;
    assign result.target = base + offset;

endmodule

//--- decode_golden.txt
# kind pre_addr pre_data pc inst | ex: v we dest ld rdy data | mem: same | wb: we addr data | stall
# = alu mem br src1_is_pc src2_is_imm gr_we dest imm illegal rj rkd taken target
alu 01 00000011 1c000000 00100823 0 0 00 0 0 00000000 0 0 00 0 0 00000000 1 02 00000022 0
= 0 0 0 0 0 1 03 00000000 0 00000011 00000022 0 00000000
fwd_ex 05 00000055 1c000004 001118a4 1 1 05 0 0 000000e5 1 1 05 0 1 000000a5 1 06 00000066 0
= 1 0 0 0 0 1 04 00000000 0 000000e5 00000066 0 00000000
fwd_mem 09 00000099 1c000008 001518a7 0 1 05 0 0 000000e5 1 1 05 0 1 000000a5 1 05 000000b5 0
= 6 0 0 0 0 1 07 00000000 0 000000a5 00000066 0 00000000
fwd_r0 00 00001234 1c00000c 0015812a 1 1 00 0 0 0000dead 1 1 00 0 1 0000beef 1 00 0000cafe 0
= 7 0 0 0 0 1 0a 00000000 0 00000099 00000000 0 00000000
addi 1f 00000031 1c000010 02bffc2b 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 0 0 1 1 0b ffffffff 0 00000011 00000031 0 00000000
ld_w 08 00000088 1c000014 2880204c 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 3 0 0 1 1 0c 00000008 0 00000022 00000088 0 00000000
st_b 0d 00000013 1c000018 293ff0a6 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 6 0 0 1 0 06 fffffffc 0 000000b5 00000066 0 00000000
load_use 0c 000000cc 1c00001c 0010058e 1 1 0c 1 0 000000c0 0 0 00 0 0 00000000 0 00 00000000 3
= 0 0 0 0 0 1 0e 00000000 0 000000cc 00000011 0 00000000
illegal 0f 00000015 1c000020 ffffffff 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 0 0 0 0 1f 00000000 1 00000031 00000031 0 00000000
beq 14 00000014 1c000024 58001021 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 4 0 0 0 01 00000010 0 00000011 00000011 1 1c000034
bltu 15 00000015 1c000028 68002041 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 8 0 0 0 01 00000020 0 00000022 00000011 0 00000000
blt 10 fffffff0 1c00002c 63fffa01 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 6 0 0 0 01 fffffff8 0 fffffff0 00000011 1 1c000024
bl 17 00000017 1c000030 54040000 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 2 1 1 1 01 00000004 0 00000000 00000000 1 1c000430
jirl 18 00000018 1c000034 4c004020 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= 0 0 3 1 1 1 00 00000004 0 00000011 fffffff0 1 00000051
lu12i 1a 00000026 1c000038 142468b1 0 0 00 0 0 00000000 0 0 00 0 0 00000000 0 00 00000000 0
= b 0 0 0 1 1 11 12345000 0 000000b5 00000026 0 00000000

//--- decode_pkg.sv
package decode_pkg;

    // fixed by the LA32 integer ISA
    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    // rj plus rk or rd
    localparam int NUM_READ_PORTS = 2;

    // opcode fields over inst[31:15], laid out as op[31:26]_op[25:22]_op[21:20]_op[19:15]
    // ? bits are don't care and only make sense under casez
    // three register ops
    localparam logic [16:0] OPC_ADD_W     = 17'b000000_0000_01_00000;
    localparam logic [16:0] OPC_SUB_W     = 17'b000000_0000_01_00010;
    localparam logic [16:0] OPC_SLT       = 17'b000000_0000_01_00100;
    localparam logic [16:0] OPC_SLTU      = 17'b000000_0000_01_00101;
    localparam logic [16:0] OPC_NOR       = 17'b000000_0000_01_01000;
    localparam logic [16:0] OPC_AND       = 17'b000000_0000_01_01001;
    localparam logic [16:0] OPC_OR        = 17'b000000_0000_01_01010;
    localparam logic [16:0] OPC_XOR       = 17'b000000_0000_01_01011;
    localparam logic [16:0] OPC_SLL_W     = 17'b000000_0000_01_01110;
    localparam logic [16:0] OPC_SRL_W     = 17'b000000_0000_01_01111;
    localparam logic [16:0] OPC_SRA_W     = 17'b000000_0000_01_10000;
    // shift by ui5
    localparam logic [16:0] OPC_SLLI_W    = 17'b000000_0001_00_00001;
    localparam logic [16:0] OPC_SRLI_W    = 17'b000000_0001_00_01001;
    localparam logic [16:0] OPC_SRAI_W    = 17'b000000_0001_00_10001;
    // 12 bit immediate ops
    localparam logic [16:0] OPC_SLTI      = 17'b000000_1000_??_?????;
    localparam logic [16:0] OPC_SLTIU     = 17'b000000_1001_??_?????;
    localparam logic [16:0] OPC_ADDI_W    = 17'b000000_1010_??_?????;
    localparam logic [16:0] OPC_ANDI      = 17'b000000_1101_??_?????;
    localparam logic [16:0] OPC_ORI       = 17'b000000_1110_??_?????;
    localparam logic [16:0] OPC_XORI      = 17'b000000_1111_??_?????;
    // 20 bit immediate, inst[25] must be clear
    localparam logic [16:0] OPC_LU12I_W   = 17'b000101_0???_??_?????;
    localparam logic [16:0] OPC_PCADDU12I = 17'b000111_0???_??_?????;
    // loads and stores
    localparam logic [16:0] OPC_LD_B      = 17'b001010_0000_??_?????;
    localparam logic [16:0] OPC_LD_H      = 17'b001010_0001_??_?????;
    localparam logic [16:0] OPC_LD_W      = 17'b001010_0010_??_?????;
    localparam logic [16:0] OPC_ST_B      = 17'b001010_0100_??_?????;
    localparam logic [16:0] OPC_ST_H      = 17'b001010_0101_??_?????;
    localparam logic [16:0] OPC_ST_W      = 17'b001010_0110_??_?????;
    localparam logic [16:0] OPC_LD_BU     = 17'b001010_1000_??_?????;
    localparam logic [16:0] OPC_LD_HU     = 17'b001010_1001_??_?????;
    // jumps and branches, only op[31:26] counts
    localparam logic [16:0] OPC_JIRL      = 17'b010011_????_??_?????;
    localparam logic [16:0] OPC_B         = 17'b010100_????_??_?????;
    localparam logic [16:0] OPC_BL        = 17'b010101_????_??_?????;
    localparam logic [16:0] OPC_BEQ       = 17'b010110_????_??_?????;
    localparam logic [16:0] OPC_BNE       = 17'b010111_????_??_?????;
    localparam logic [16:0] OPC_BLT       = 17'b011000_????_??_?????;
    localparam logic [16:0] OPC_BGE       = 17'b011001_????_??_?????;
    localparam logic [16:0] OPC_BLTU      = 17'b011010_????_??_?????;
    localparam logic [16:0] OPC_BGEU      = 17'b011011_????_??_?????;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_H, MEM_LD_W, MEM_LD_BU,
        MEM_LD_HU, MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_B, BR_BL, BR_JIRL, BR_BEQ,
        BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_bundle_t;

    // one in-flight producer seen from decode
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] dest;
        logic                  is_load;
        // memory stage already holds the load data
        logic                  data_ready;
        logic [XLEN-1:0]       wdata;
    } bypass_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
    } read_req_t;

    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        br_op_e                br_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
    } decode_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] rj_value;
        logic [XLEN-1:0] rkd_value;
    } issue_bundle_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetch_valid,
    output logic          fetch_ready,
    input  fetch_bundle_t fetch,
    input  bypass_t       ex_bypass,
    input  bypass_t       mem_bypass,
    input  rf_write_t     wb_write,
    output logic          issue_valid,
    input  logic          issue_ready,
    output issue_bundle_t issue,
    output redirect_t     redirect
);

    fetch_bundle_t         held;
    logic                  held_valid;
    decode_ctrl_t          ctrl;
    read_req_t             read_req [NUM_READ_PORTS];
    logic [REG_ADDR_W-1:0] rf_raddr [NUM_READ_PORTS];
    logic [XLEN-1:0]       rf_rdata [NUM_READ_PORTS];
    logic [XLEN-1:0]       fwd_value [NUM_READ_PORTS];
    logic [NUM_READ_PORTS-1:0] port_hazard;
    logic                  issue_fire;
    logic [XLEN-1:0]       off16;
    logic [XLEN-1:0]       off26;
    logic                  br_is_far;
    redirect_t             br_result;

    // stage handshake
    // any port waiting on a load holds the word back
    assign issue_valid = held_valid && !(|port_hazard);
    assign issue_fire  = issue_valid && issue_ready;
    assign fetch_ready = !held_valid || issue_fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (fetch_ready) begin
            held_valid <= fetch_valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            held <= fetch;
        end
    end

    inst_decoder i_inst_decoder (
        .inst     (held.inst),
        .ctrl     (ctrl),
        .read_req (read_req)
    );

    regfile i_regfile (
        .clk   (clk),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .write (wb_write)
    );

    // one forwarding mux per source operand
    for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_port
        assign rf_raddr[p] = read_req[p].addr;

        operand_forward i_operand_forward (
            .req        (read_req[p]),
            .rf_data    (rf_rdata[p]),
            .ex_bypass  (ex_bypass),
            .mem_bypass (mem_bypass),
            .wb_write   (wb_write),
            .value      (fwd_value[p]),
            .hazard     (port_hazard[p])
        );
    end

    // ctrl.imm holds the link constant for bl and jirl
    // so the jump offset comes straight from the word
    assign off16     = {{14{held.inst[25]}}, held.inst[25:10], 2'b00};
    assign off26     = {{4{held.inst[9]}}, held.inst[9:0], held.inst[25:10], 2'b00};
    assign br_is_far = (ctrl.br_op == BR_B) || (ctrl.br_op == BR_BL);

    branch_unit i_branch_unit (
        .pc        (held.pc),
        .br_op     (ctrl.br_op),
        .offset    (br_is_far ? off26 : off16),
        .rj_value  (fwd_value[0]),
        .rkd_value (fwd_value[1]),
        .result    (br_result)
    );

    assign issue.pc        = held.pc;
    assign issue.ctrl      = ctrl;
    assign issue.rj_value  = fwd_value[0];
    assign issue.rkd_value = fwd_value[1];

    // fetch redirect only once the branch actually leaves decode
    assign redirect.taken  = issue_fire && br_result.taken;
    assign redirect.target = br_result.target;

    // an offered bundle waits unchanged for the sink
    a_issue_stable: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> $stable(issue))
        else $error("issue bundle changed while stalled by the sink");

    // fetch side keeps an unaccepted word in place
    a_fetch_stable: assert property (@(posedge clk) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch))
        else $error("fetch bundle dropped or changed before acceptance");

endmodule

//--- files.f
decode_pkg.sv
inst_decoder.sv
regfile.sv
operand_forward.sv
branch_unit.sv
decode_stage.sv
tb_decode_stage.sv

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output decode_ctrl_t    ctrl,
    output read_req_t       read_req [NUM_READ_PORTS]
);

    // operand and immediate layout of a word
    typedef enum logic [3:0] {
        // outside the subset
        F_ILL,
        F_3R,
        F_UI5,
        // rj + si12, alu op or load
        F_SI12,
        F_UI12,
        // store, rd is the data source
        F_ST,
        F_LUI,
        F_PCADD,
        F_JIRL,
        F_B,
        F_BL,
        // conditional branch, rj against rd
        F_BCC
    } fmt_e;

    typedef struct packed {
        fmt_e    fmt;
        alu_op_e alu;
        mem_op_e mem;
        br_op_e  br;
    } op_info_t;

    op_info_t              info;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic [XLEN-1:0]       imm;
    logic                  rj_used;
    logic                  rkd_used;
    logic                  rd_is_src;

    // register fields sit at the same place in every format
    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // one opcode match per kept instruction
    always_comb begin
        unique casez (inst[31:15])
            OPC_ADD_W:     info = '{F_3R, ALU_ADD, MEM_NONE, BR_NONE};
            OPC_SUB_W:     info = '{F_3R, ALU_SUB, MEM_NONE, BR_NONE};
            OPC_SLT:       info = '{F_3R, ALU_SLT, MEM_NONE, BR_NONE};
            OPC_SLTU:      info = '{F_3R, ALU_SLTU, MEM_NONE, BR_NONE};
            OPC_NOR:       info = '{F_3R, ALU_NOR, MEM_NONE, BR_NONE};
            OPC_AND:       info = '{F_3R, ALU_AND, MEM_NONE, BR_NONE};
            OPC_OR:        info = '{F_3R, ALU_OR, MEM_NONE, BR_NONE};
            OPC_XOR:       info = '{F_3R, ALU_XOR, MEM_NONE, BR_NONE};
            OPC_SLL_W:     info = '{F_3R, ALU_SLL, MEM_NONE, BR_NONE};
            OPC_SRL_W:     info = '{F_3R, ALU_SRL, MEM_NONE, BR_NONE};
            OPC_SRA_W:     info = '{F_3R, ALU_SRA, MEM_NONE, BR_NONE};
            OPC_SLLI_W:    info = '{F_UI5, ALU_SLL, MEM_NONE, BR_NONE};
            OPC_SRLI_W:    info = '{F_UI5, ALU_SRL, MEM_NONE, BR_NONE};
            OPC_SRAI_W:    info = '{F_UI5, ALU_SRA, MEM_NONE, BR_NONE};
            OPC_SLTI:      info = '{F_SI12, ALU_SLT, MEM_NONE, BR_NONE};
            OPC_SLTIU:     info = '{F_SI12, ALU_SLTU, MEM_NONE, BR_NONE};
            OPC_ADDI_W:    info = '{F_SI12, ALU_ADD, MEM_NONE, BR_NONE};
            OPC_ANDI:      info = '{F_UI12, ALU_AND, MEM_NONE, BR_NONE};
            OPC_ORI:       info = '{F_UI12, ALU_OR, MEM_NONE, BR_NONE};
            OPC_XORI:      info = '{F_UI12, ALU_XOR, MEM_NONE, BR_NONE};
            OPC_LU12I_W:   info = '{F_LUI, ALU_LUI, MEM_NONE, BR_NONE};
            OPC_PCADDU12I: info = '{F_PCADD, ALU_ADD, MEM_NONE, BR_NONE};
            // address is always rj + si12 through the adder
            OPC_LD_B:      info = '{F_SI12, ALU_ADD, MEM_LD_B, BR_NONE};
            OPC_LD_H:      info = '{F_SI12, ALU_ADD, MEM_LD_H, BR_NONE};
            OPC_LD_W:      info = '{F_SI12, ALU_ADD, MEM_LD_W, BR_NONE};
            OPC_LD_BU:     info = '{F_SI12, ALU_ADD, MEM_LD_BU, BR_NONE};
            OPC_LD_HU:     info = '{F_SI12, ALU_ADD, MEM_LD_HU, BR_NONE};
            OPC_ST_B:      info = '{F_ST, ALU_ADD, MEM_ST_B, BR_NONE};
            OPC_ST_H:      info = '{F_ST, ALU_ADD, MEM_ST_H, BR_NONE};
            OPC_ST_W:      info = '{F_ST, ALU_ADD, MEM_ST_W, BR_NONE};
            // link value pc + 4 also goes through the adder
            OPC_JIRL:      info = '{F_JIRL, ALU_ADD, MEM_NONE, BR_JIRL};
            OPC_B:         info = '{F_B, ALU_ADD, MEM_NONE, BR_B};
            OPC_BL:        info = '{F_BL, ALU_ADD, MEM_NONE, BR_BL};
            OPC_BEQ:       info = '{F_BCC, ALU_ADD, MEM_NONE, BR_BEQ};
            OPC_BNE:       info = '{F_BCC, ALU_ADD, MEM_NONE, BR_BNE};
            OPC_BLT:       info = '{F_BCC, ALU_ADD, MEM_NONE, BR_BLT};
            OPC_BGE:       info = '{F_BCC, ALU_ADD, MEM_NONE, BR_BGE};
            OPC_BLTU:      info = '{F_BCC, ALU_ADD, MEM_NONE, BR_BLTU};
            OPC_BGEU:      info = '{F_BCC, ALU_ADD, MEM_NONE, BR_BGEU};
            default:       info = '{F_ILL, ALU_ADD, MEM_NONE, BR_NONE};
        endcase
    end

    // immediate by format
    always_comb begin
        case (info.fmt)
            F_UI5:          imm = {{(XLEN-REG_ADDR_W){1'b0}}, rk};
            F_SI12, F_ST:   imm = {{20{inst[21]}}, inst[21:10]};
            F_UI12:         imm = {20'b0, inst[21:10]};
            F_LUI, F_PCADD: imm = {inst[24:5], 12'b0};
            // link address offset
            F_JIRL, F_BL:   imm = XLEN'(4);
            F_BCC:          imm = {{14{inst[25]}}, inst[25:10], 2'b00};
            // offs26 is split, high part in inst[9:0]
            F_B:            imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            default:        imm = '0;
        endcase
    end

    assign rj_used   = info.fmt inside {F_3R, F_UI5, F_SI12, F_UI12, F_ST, F_JIRL, F_BCC};
    assign rkd_used  = info.fmt inside {F_3R, F_ST, F_BCC};
    assign rd_is_src = info.fmt inside {F_ST, F_BCC};

    assign ctrl.alu_op      = info.alu;
    assign ctrl.mem_op      = info.mem;
    assign ctrl.br_op       = info.br;
    assign ctrl.src1_is_pc  = info.fmt inside {F_PCADD, F_JIRL, F_BL};
    assign ctrl.src2_is_imm = !(info.fmt inside {F_ILL, F_3R, F_B, F_BCC});
    // no write for stores, plain branches and unknown words
    assign ctrl.gr_we       = !(info.fmt inside {F_ILL, F_ST, F_B, F_BCC});
    // bl links into r1
    assign ctrl.dest        = (info.fmt == F_BL) ? REG_ADDR_W'(1) : rd;
    assign ctrl.imm         = imm;
    assign ctrl.illegal     = (info.fmt == F_ILL);

    // port 0 is rj, port 1 is rk or rd
    assign read_req[0].en   = rj_used;
    assign read_req[0].addr = rj;
    assign read_req[1].en   = rkd_used;
    assign read_req[1].addr = rd_is_src ? rd : rk;

endmodule

//--- operand_forward.sv
`timescale 1ns/1ps

module operand_forward import decode_pkg::*; (
    input  read_req_t       req,
    input  logic [XLEN-1:0] rf_data,
    input  bypass_t         ex_bypass,
    input  bypass_t         mem_bypass,
    input  rf_write_t       wb_write,
    output logic [XLEN-1:0] value,
    output logic            hazard
);

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // live producer writing the nonzero register this port reads
    function automatic logic stage_hit(input bypass_t p, input read_req_t r);
        return r.en && p.valid && p.we && (p.dest != '0) && (p.dest == r.addr);
    endfunction

    assign ex_hit  = stage_hit(ex_bypass, req);
    assign mem_hit = stage_hit(mem_bypass, req);
    // writeback port has no valid bit, we alone qualifies it
    assign wb_hit  = req.en && wb_write.we && (wb_write.waddr != '0) &&
                     (wb_write.waddr == req.addr);

    // youngest producer first
    always_comb begin
        if (ex_hit) begin
            value = ex_bypass.wdata;
        end else if (mem_hit) begin
            value = mem_bypass.wdata;
        end else if (wb_hit) begin
            value = wb_write.wdata;
        end else begin
            value = rf_data;
        end
    end

    // load in execute never has data yet
    // load in memory only once data_ready is up
    assign hazard = (ex_hit && ex_bypass.is_load) ||
                    (mem_hit && mem_bypass.is_load && !mem_bypass.data_ready);

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile import decode_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr [NUM_READ_PORTS],
    output logic [XLEN-1:0]       rdata [NUM_READ_PORTS],
    input  rf_write_t             write
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // single write port, updated at the edge
    always_ff @(posedge clk) begin
        if (write.we) begin
            regs[write.waddr] <= write.wdata;
        end
    end

    // reads are combinational
    // a same-cycle write is seen through writeback forwarding instead
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            // r0 is hardwired zero whatever the array holds
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

//--- tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int MAX_VEC    = 64;
    localparam int CLK_PERIOD = 4;

    logic          clk;
    logic          reset;
    logic          fetch_valid;
    logic          fetch_ready;
    fetch_bundle_t fetch;
    bypass_t       ex_bypass;
    bypass_t       mem_bypass;
    rf_write_t     wb_write;
    logic          issue_valid;
    logic          issue_ready;
    issue_bundle_t issue;
    redirect_t     redirect;

    // vector storage, one entry per golden line pair
    string         kind [MAX_VEC];
    rf_write_t     preload [MAX_VEC];
    fetch_bundle_t vec_fetch [MAX_VEC];
    bypass_t       vec_ex [MAX_VEC];
    bypass_t       vec_mem [MAX_VEC];
    rf_write_t     vec_wb [MAX_VEC];
    int            vec_stall [MAX_VEC];
    decode_ctrl_t  exp_ctrl [MAX_VEC];
    logic [31:0]   exp_rj [MAX_VEC];
    logic [31:0]   exp_rkd [MAX_VEC];
    redirect_t     exp_redirect [MAX_VEC];

    int            nvec;
    int            check_errors;
    int            other_errors;
    int            issued;
    logic [31:0]   lfsr_state;
    bit            loaded;

    decode_stage i_decode_stage (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .ex_bypass   (ex_bypass),
        .mem_bypass  (mem_bypass),
        .wb_write    (wb_write),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .redirect    (redirect)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form, taps on the high bits
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    task automatic take_ready_bit();
        lfsr_state  = lfsr_next(lfsr_state);
        issue_ready = lfsr_state[0];
    endtask

    task automatic fail_value(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        check_errors++;
    endtask

    // stimulus line, then a line starting with = that holds the expected issue
    task automatic load_vectors();
        int          fd;
        string       line;
        logic [31:0] s [20];
        logic [31:0] e [13];
        bit          have_stim;
        fd        = $fopen("decode_golden.txt", "r");
        have_stim = 0;
        nvec      = 0;
        if (fd == 0) begin
            $display("could not open decode_golden.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd) && nvec < MAX_VEC) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 4 || line[0] == "#") continue;
            if (!have_stim) begin
                void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                    kind[nvec], s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7], s[8], s[9],
                    s[10], s[11], s[12], s[13], s[14], s[15], s[16], s[17], s[18], s[19]));
                preload[nvec]   = '{1'b1, s[0][4:0], s[1]};
                vec_fetch[nvec] = '{s[2], s[3]};
                vec_ex[nvec]    = '{s[4][0], s[5][0], s[6][4:0], s[7][0], s[8][0], s[9]};
                vec_mem[nvec]   = '{s[10][0], s[11][0], s[12][4:0], s[13][0], s[14][0], s[15]};
                vec_wb[nvec]    = '{s[16][0], s[17][4:0], s[18]};
                vec_stall[nvec] = s[19];
                have_stim       = 1;
            end else begin
                void'($sscanf(line, "= %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7], e[8], e[9], e[10],
                    e[11], e[12]));
                exp_ctrl[nvec] = '{alu_op_e'(e[0][3:0]), mem_op_e'(e[1][3:0]),
                    br_op_e'(e[2][3:0]), e[3][0], e[4][0], e[5][0], e[6][4:0], e[7], e[8][0]};
                exp_rj[nvec]       = e[9];
                exp_rkd[nvec]      = e[10];
                exp_redirect[nvec] = '{e[11][0], e[12]};
                have_stim          = 0;
                nvec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_issue(input int k);
        assert (issue.pc === vec_fetch[k].pc)
            else fail_value($sformatf("%s pc %h, expected %h", kind[k], issue.pc,
                vec_fetch[k].pc));
        assert (issue.ctrl === exp_ctrl[k])
            else fail_value($sformatf("%s ctrl %h, expected %h", kind[k], issue.ctrl,
                exp_ctrl[k]));
        assert (issue.rj_value === exp_rj[k])
            else fail_value($sformatf("%s rj %h, expected %h", kind[k], issue.rj_value,
                exp_rj[k]));
        assert (issue.rkd_value === exp_rkd[k])
            else fail_value($sformatf("%s rkd %h, expected %h", kind[k], issue.rkd_value,
                exp_rkd[k]));
        assert (redirect.taken === exp_redirect[k].taken)
            else fail_value($sformatf("%s redirect taken %b", kind[k], redirect.taken));
        if (exp_redirect[k].taken) begin
            assert (redirect.target === exp_redirect[k].target)
                else fail_value($sformatf("%s target %h, expected %h", kind[k],
                    redirect.target, exp_redirect[k].target));
        end
        issued++;
    endtask

    task automatic run_vector(input int k);
        issue_bundle_t held_issue;
        logic          waiting;
        logic          done;
        // quiet bypasses, one preload write lands at the next edge
        @(posedge clk);
        #1;
        ex_bypass  = '0;
        mem_bypass = '0;
        wb_write   = preload[k];
        @(posedge clk);
        #1;
        wb_write    = vec_wb[k];
        ex_bypass   = vec_ex[k];
        mem_bypass  = vec_mem[k];
        fetch       = vec_fetch[k];
        fetch_valid = 1'b1;
        @(negedge clk);
        assert (fetch_ready) else fail_value("fetch_ready low with an empty stage");
        assert (!issue_valid) else fail_value("issue_valid high with an empty stage");
        assert (!redirect.taken) else fail_value("redirect taken with an empty stage");
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        // load in execute must hold the word back
        repeat (vec_stall[k]) begin
            @(negedge clk);
            assert (!issue_valid) else fail_value($sformatf("%s issued under load-use", kind[k]));
            assert (!fetch_ready) else fail_value("fetch_ready high while stalled");
            @(posedge clk);
            #1;
        end
        if (vec_stall[k] > 0) begin
            ex_bypass.valid = 1'b0;
        end
        waiting = 1'b0;
        done    = 1'b0;
        while (!done) begin
            take_ready_bit();
            @(negedge clk);
            if (waiting) begin
                assert (issue === held_issue) else fail_value("issue changed while waiting");
            end
            if (issue_valid && issue_ready) begin
                check_issue(k);
                done = 1'b1;
            end else begin
                assert (!redirect.taken) else fail_value("redirect without handshake");
                assert (!fetch_ready) else fail_value("fetch_ready high while stage full");
                waiting    = issue_valid;
                held_issue = issue;
            end
            @(posedge clk);
            #1;
        end
        issue_ready = 1'b0;
        @(negedge clk);
        assert (!issue_valid) else fail_value($sformatf("%s offered a second time", kind[k]));
    endtask

    initial begin
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch        = '0;
        ex_bypass    = '0;
        mem_bypass   = '0;
        wb_write     = '0;
        issue_ready  = 1'b0;
        check_errors = 0;
        other_errors = 0;
        issued       = 0;
        loaded       = 0;
        lfsr_state   = 32'h2ab3_5110;
        load_vectors();
        loaded = 1;
        // ten edges in reset, last check just after release
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            #1;
            if (c == 9) begin
                reset = 1'b0;
            end
            @(negedge clk);
            assert (!issue_valid) else fail_value("issue_valid high in reset");
            assert (!redirect.taken) else fail_value("redirect taken in reset");
            assert (fetch_ready) else fail_value("fetch_ready low in reset");
        end
        for (int k = 0; k < nvec; k++) begin
            run_vector(k);
        end
        $display("errors: %0d check, %0d other; %0d of %0d vectors issued",
            check_errors, other_errors, issued, nvec);
        if (check_errors == 0 && other_errors == 0 && nvec > 0 && issued == nvec) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // bound by the vector count
    initial begin
        wait (loaded);
        repeat ((nvec + 1) * 40 + 20) @(posedge clk);
        $display("timeout: the decode stage did not get through the vectors in time");
        $display("errors: %0d check, %0d other", check_errors, other_errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
